// ==== vlog.f ====
+incdir+design
design/xfcp_pkg.sv
design/xfcp_arb_2x1.sv
design/xfcp_route_1x2.sv
design/xfcp_wb_target.sv
design/wb_ram.sv
design/xfcp_core.sv
bench/xfcp_core_props.sv
bench/tb_xfcp_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the XFCP core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_xfcp_core -f vlog.f -o sim_tb_xfcp_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_xfcp_core +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0

// ==== bench/tb_xfcp_core.sv ====
// XFCP core testbench
// Drives both host ports, keeps a model of each RAM and checks every response
`timescale 1ns/10ps
`include "xfcp_defs.svh"

module tb_xfcp_core
    import xfcp_pkg::*;
();

    localparam int TIMEOUT = 1000;
    localparam logic [7:0] RSP_RD = 8'h11;
    localparam logic [7:0] RSP_WR = 8'h13;

    typedef logic [7:0] bytes_t [$];

    logic        clk;
    logic        rst_i;
    xfcp_beat_t  req_beat  [2];
    logic        req_valid [2];
    logic        req_ready [2];
    xfcp_beat_t  rsp_beat  [2];
    logic        rsp_valid [2];
    logic        rsp_ready [2];
    logic        stall_en  [2];
    logic [31:0] bp_state  [2];
    logic [31:0] data_state;
    logic [31:0] model [2][256];
    int          errors;
    int          passed;
    int          failed;

    xfcp_core u_dut (
        .clk               (clk),
        .rst_i             (rst_i),
        .host0_req_i       (req_beat[0]),
        .host0_req_valid_i (req_valid[0]),
        .host0_req_ready_o (req_ready[0]),
        .host0_rsp_o       (rsp_beat[0]),
        .host0_rsp_valid_o (rsp_valid[0]),
        .host0_rsp_ready_i (rsp_ready[0]),
        .host1_req_i       (req_beat[1]),
        .host1_req_valid_i (req_valid[1]),
        .host1_req_ready_o (req_ready[1]),
        .host1_rsp_o       (rsp_beat[1]),
        .host1_rsp_valid_o (rsp_valid[1]),
        .host1_rsp_ready_i (rsp_ready[1])
    );

    bind xfcp_core xfcp_core_props u_props (
        .clk          (clk),
        .rst_i        (rst_i),
        .rsp0_i       (host0_rsp_o),
        .rsp0_valid_i (host0_rsp_valid_o),
        .rsp0_ready_i (host0_rsp_ready_i),
        .rsp1_i       (host1_rsp_o),
        .rsp1_valid_i (host1_rsp_valid_o),
        .rsp1_ready_i (host1_rsp_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit of the word
    task automatic random_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            data_state = lfsr_step(data_state);
            w[b] = data_state[0];
        end
    endtask

    // Response ready pattern, one random bit per host per cycle when stalling
    initial begin
        bp_state[0] = 32'd87;
        bp_state[1] = 32'd87;
        rsp_ready[0] = 1'b1;
        rsp_ready[1] = 1'b1;
        forever begin
            @(posedge clk);
            bp_state[0] = lfsr_step(bp_state[0]);
            bp_state[1] = lfsr_step(bp_state[1]);
            rsp_ready[0] <= !stall_en[0] || bp_state[0][0];
            rsp_ready[1] <= !stall_en[1] || bp_state[1][0];
        end
    end

    task automatic send_packet(input logic h, input bytes_t pkt);
        int t;
        for (int i = 0; i < pkt.size(); i++) begin
            req_beat[h]  <= '{data: pkt[i], last: (i == pkt.size() - 1)};
            req_valid[h] <= 1'b1;
            t = 0;
            @(negedge clk);
            while (!req_ready[h]) begin
                if (t == TIMEOUT) begin
                    $display("timeout: host%0d request beat %0d was never accepted", h, i);
                    errors++;
                    @(posedge clk);
                    req_valid[h] <= 1'b0;
                    return;
                end
                t++;
                @(negedge clk);
            end
            @(posedge clk);
        end
        req_valid[h] <= 1'b0;
    endtask

    // Beats are taken at the falling edge before the transfer edge
    task automatic recv_packet(input logic h, output bytes_t got);
        int   t;
        logic done;
        got = {};
        t = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (rsp_valid[h] && rsp_ready[h]) begin
                got.push_back(rsp_beat[h].data);
                done = rsp_beat[h].last;
                t = 0;
            end else if (t == TIMEOUT) begin
                $display("timeout: host%0d never finished its response", h);
                errors++;
                done = 1'b1;
            end else begin
                t++;
            end
        end
        @(posedge clk);
    endtask

    task automatic check_rsp(input logic h, input bytes_t got, input bytes_t exp);
        assert (got.size() == exp.size()) else begin
            $display("mismatch host%0d_rsp_o length: got 0x%0h expected 0x%0h",
                     h, got.size(), exp.size());
            errors++;
        end
        for (int i = 0; i < got.size() && i < exp.size(); i++) begin
            assert (got[i] == exp[i]) else begin
                $display("mismatch host%0d_rsp_o.data byte %0d: got 0x%02h expected 0x%02h",
                         h, i, got[i], exp[i]);
                errors++;
            end
        end
    endtask

    task automatic transact(input logic h, input bytes_t req, input bytes_t exp,
                            output bytes_t got);
        send_packet(h, req);
        recv_packet(h, got);
        check_rsp(h, got, exp);
    endtask

    task automatic write_words(input logic h, input logic port, input logic [7:0] adr,
                               input int n);
        bytes_t      req;
        bytes_t      exp;
        bytes_t      got;
        logic [31:0] w;
        req = {8'(port), `XFCP_CMD_WRITE, adr, 8'(n)};
        for (int k = 0; k < n; k++) begin
            random_word(w);
            model[port][adr + 8'(k)] = w;
            for (int b = 0; b < 4; b++) begin
                req.push_back(w[b*8 +: 8]);
            end
        end
        exp = {RSP_WR, adr, 8'(n)};
        transact(h, req, exp, got);
    endtask

    task automatic read_words(input logic h, input logic port, input logic [7:0] adr,
                              input int n, output bytes_t got);
        bytes_t      req;
        bytes_t      exp;
        logic [31:0] w;
        req = {8'(port), `XFCP_CMD_READ, adr, 8'(n)};
        exp = {RSP_RD, adr, 8'(n)};
        for (int k = 0; k < n; k++) begin
            w = model[port][adr + 8'(k)];
            for (int b = 0; b < 4; b++) begin
                exp.push_back(w[b*8 +: 8]);
            end
        end
        transact(h, req, exp, got);
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            failed++;
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
        end
    endtask

    initial begin
        int     e;
        bytes_t got_a;
        bytes_t got_b;
        bytes_t req;
        bytes_t exp;
        rst_i = 1'b1;
        req_beat[0] = '0;
        req_beat[1] = '0;
        req_valid[0] = 1'b0;
        req_valid[1] = 1'b0;
        stall_en[0] = 1'b1;
        stall_en[1] = 1'b1;
        data_state = 32'd87;
        errors = 0;
        passed = 0;
        failed = 0;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);

        e = errors;
        write_words(1'b0, 1'b0, 8'h20, 4);
        read_words(1'b0, 1'b0, 8'h20, 4, got_a);
        end_test(1, "host0 write and read back ram0", e);

        e = errors;
        write_words(1'b1, 1'b1, 8'h20, 4);
        read_words(1'b1, 1'b0, 8'h20, 4, got_a);
        read_words(1'b0, 1'b1, 8'h20, 4, got_b);
        end_test(2, "ram0 and ram1 keep separate data", e);

        // Host 0 reads ram1 while host 1 reads ram0
        e = errors;
        fork
            read_words(1'b0, 1'b1, 8'h20, 4, got_a);
            read_words(1'b1, 1'b0, 8'h20, 4, got_b);
        join
        end_test(3, "simultaneous hosts", e);

        e = errors;
        write_words(1'b0, 1'b0, 8'hFE, 3);
        read_words(1'b0, 1'b0, 8'h00, 1, got_a);
        end_test(4, "address wrap", e);

        e = errors;
        req = {8'h02, `XFCP_CMD_READ, 8'h20, 8'h01};
        send_packet(1'b0, req);
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            assert (!rsp_valid[0]) else begin
                $display("host0 got a response to a request for a missing port");
                errors++;
            end
        end
        @(posedge clk);
        read_words(1'b0, 1'b0, 8'h20, 2, got_a);
        req = {8'h00, 8'h20, 8'h40, 8'h05};
        exp = {8'hFF, 8'h40, 8'h05};
        transact(1'b0, req, exp, got_a);
        end_test(5, "dropped port and unknown command", e);

        e = errors;
        write_words(1'b0, 1'b0, 8'h80, 8);
        stall_en[0] <= 1'b0;
        @(posedge clk);
        read_words(1'b0, 1'b0, 8'h80, 8, got_a);
        stall_en[0] <= 1'b1;
        @(posedge clk);
        read_words(1'b0, 1'b0, 8'h80, 8, got_b);
        check_rsp(1'b0, got_b, got_a);
        end_test(6, "read under back-pressure", e);

        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 passed, failed, u_dut.u_props.fail_count);
        if (failed == 0 && u_dut.u_props.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== bench/xfcp_core_props.sv ====
// XFCP core response checks
// Bound into the core, watches the handshakes on both host response ports
`timescale 1ns/10ps

module xfcp_core_props
    import xfcp_pkg::*;
(
    input logic       clk,
    input logic       rst_i,
    input xfcp_beat_t rsp0_i,
    input logic       rsp0_valid_i,
    input logic       rsp0_ready_i,
    input xfcp_beat_t rsp1_i,
    input logic       rsp1_valid_i,
    input logic       rsp1_ready_i
);

    int unsigned fail_count = 0;

    // A stalled beat stays put until the host takes it
    a_rsp0_hold: assert property (@(posedge clk) disable iff (rst_i)
        rsp0_valid_i && !rsp0_ready_i |=> rsp0_valid_i && $stable(rsp0_i))
    else begin
        $error("host0 response beat changed or dropped while stalled");
        fail_count++;
    end

    a_rsp1_hold: assert property (@(posedge clk) disable iff (rst_i)
        rsp1_valid_i && !rsp1_ready_i |=> rsp1_valid_i && $stable(rsp1_i))
    else begin
        $error("host1 response beat changed or dropped while stalled");
        fail_count++;
    end

    a_rst_quiet: assert property (@(posedge clk)
        rst_i |-> !rsp0_valid_i && !rsp1_valid_i)
    else begin
        $error("response valid high during reset");
        fail_count++;
    end

    // Only the lock owner ever sees a response
    a_one_owner: assert property (@(posedge clk) disable iff (rst_i)
        !(rsp0_valid_i && rsp1_valid_i))
    else begin
        $error("both host response valids high together");
        fail_count++;
    end

endmodule

// ==== design/xfcp_core.sv ====
// XFCP control-plane core
// Two host ports share one 2x1 arbiter, and a 1x2 router feeds two
// Wishbone RAM targets
`timescale 1ns/10ps

module xfcp_core
    import xfcp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  xfcp_beat_t host0_req_i,
    input  logic       host0_req_valid_i,
    output logic       host0_req_ready_o,
    output xfcp_beat_t host0_rsp_o,
    output logic       host0_rsp_valid_o,
    input  logic       host0_rsp_ready_i,
    input  xfcp_beat_t host1_req_i,
    input  logic       host1_req_valid_i,
    output logic       host1_req_ready_o,
    output xfcp_beat_t host1_rsp_o,
    output logic       host1_rsp_valid_o,
    input  logic       host1_rsp_ready_i
);

    // Host side gathered into arrays for the arbiter
    xfcp_beat_t host_req       [2];
    logic       host_req_valid [2];
    logic       host_req_ready [2];
    xfcp_beat_t host_rsp       [2];
    logic       host_rsp_valid [2];
    logic       host_rsp_ready [2];

    // Arbiter to router
    xfcp_beat_t arb_req;
    logic       arb_req_valid;
    logic       arb_req_ready;
    xfcp_beat_t route_rsp;
    logic       route_rsp_valid;
    logic       route_rsp_ready;
    logic       route_drop;

    // Router to targets, targets to RAMs
    xfcp_beat_t tgt_req       [2];
    logic       tgt_req_valid [2];
    logic       tgt_req_ready [2];
    xfcp_beat_t tgt_rsp       [2];
    logic       tgt_rsp_valid [2];
    logic       tgt_rsp_ready [2];
    wb_req_t    ram_req       [2];
    wb_rsp_t    ram_rsp       [2];

    assign host_req[0]       = host0_req_i;
    assign host_req[1]       = host1_req_i;
    assign host_req_valid[0] = host0_req_valid_i;
    assign host_req_valid[1] = host1_req_valid_i;
    assign host_rsp_ready[0] = host0_rsp_ready_i;
    assign host_rsp_ready[1] = host1_rsp_ready_i;
    assign host0_req_ready_o = host_req_ready[0];
    assign host1_req_ready_o = host_req_ready[1];
    assign host0_rsp_o       = host_rsp[0];
    assign host1_rsp_o       = host_rsp[1];
    assign host0_rsp_valid_o = host_rsp_valid[0];
    assign host1_rsp_valid_o = host_rsp_valid[1];

    xfcp_arb_2x1 u_arb (
        .clk              (clk),
        .rst_i            (rst_i),
        .up_req_i         (host_req),
        .up_req_valid_i   (host_req_valid),
        .up_req_ready_o   (host_req_ready),
        .up_rsp_o         (host_rsp),
        .up_rsp_valid_o   (host_rsp_valid),
        .up_rsp_ready_i   (host_rsp_ready),
        .down_req_o       (arb_req),
        .down_req_valid_o (arb_req_valid),
        .down_req_ready_i (arb_req_ready),
        .down_rsp_i       (route_rsp),
        .down_rsp_valid_i (route_rsp_valid),
        .down_rsp_ready_o (route_rsp_ready),
        .drop_i           (route_drop)
    );

    xfcp_route_1x2 u_route (
        .clk            (clk),
        .rst_i          (rst_i),
        .up_req_i       (arb_req),
        .up_req_valid_i (arb_req_valid),
        .up_req_ready_o (arb_req_ready),
        .up_rsp_o       (route_rsp),
        .up_rsp_valid_o (route_rsp_valid),
        .up_rsp_ready_i (route_rsp_ready),
        .drop_o         (route_drop),
        .dn_req_o       (tgt_req),
        .dn_req_valid_o (tgt_req_valid),
        .dn_req_ready_i (tgt_req_ready),
        .dn_rsp_i       (tgt_rsp),
        .dn_rsp_valid_i (tgt_rsp_valid),
        .dn_rsp_ready_o (tgt_rsp_ready)
    );

    // One target and RAM per router output
    for (genvar i = 0; i < 2; i++) begin : g_ram
        xfcp_wb_target u_tgt (
            .clk         (clk),
            .rst_i       (rst_i),
            .req_i       (tgt_req[i]),
            .req_valid_i (tgt_req_valid[i]),
            .req_ready_o (tgt_req_ready[i]),
            .rsp_o       (tgt_rsp[i]),
            .rsp_valid_o (tgt_rsp_valid[i]),
            .rsp_ready_i (tgt_rsp_ready[i]),
            .wb_o        (ram_req[i]),
            .wb_i        (ram_rsp[i])
        );

        wb_ram u_ram (
            .clk   (clk),
            .rst_i (rst_i),
            .wb_i  (ram_req[i]),
            .wb_o  (ram_rsp[i])
        );
    end

endmodule

// ==== design/wb_ram.sv ====
// Wishbone RAM
// 256 words with byte-lane writes, registered read data and ack
`timescale 1ns/10ps
`include "xfcp_defs.svh"

module wb_ram
    import xfcp_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  wb_req_t wb_i,
    output wb_rsp_t wb_o
);

    logic [`WB_DATA_W-1:0] mem [2**`WB_ADDR_W];
    logic [`WB_DATA_W-1:0] dat_q;
    logic                  ack_q;
    logic                  access;

    // One access per strobe
    // The acked cycle is not repeated
    assign access = wb_i.stb && wb_i.cyc && !ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                for (int b = 0; b < `WB_SEL_W; b++) begin
                    if (wb_i.sel[b]) begin
                        mem[wb_i.adr][b*8 +: 8] <= wb_i.dat[b*8 +: 8];
                    end
                end
            end
            dat_q <= mem[wb_i.adr];
        end
    end

    assign wb_o = '{dat: dat_q, ack: ack_q};

endmodule

// ==== design/xfcp_wb_target.sv ====
// XFCP Wishbone target
// Decodes read and write command packets, runs one single-word Wishbone
// cycle per word and returns a response packet with the header first
`timescale 1ns/10ps
`include "xfcp_defs.svh"

module xfcp_wb_target
    import xfcp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  xfcp_beat_t req_i,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    output xfcp_beat_t rsp_o,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output wb_req_t    wb_o,
    input  wb_rsp_t    wb_i
);

    localparam logic [7:0] RSP_READ  = `XFCP_CMD_READ + 8'h01;
    localparam logic [7:0] RSP_WRITE = `XFCP_CMD_WRITE + 8'h01;
    localparam logic [7:0] RSP_ERR   = 8'hFF;

    typedef enum logic [3:0] {
        T_CMD, T_ADR, T_CNT, T_WDATA, T_WWB, T_DRAIN, T_HDR, T_RWB, T_RDATA
    } state_t;

    state_t                state_q;
    logic [7:0]            code_q;
    logic [`WB_ADDR_W-1:0] adr_q;
    logic [`WB_ADDR_W-1:0] ptr_q;
    logic [7:0]            cnt_q;
    logic [7:0]            left_q;
    logic [1:0]            idx_q;
    logic [`WB_DATA_W-1:0] word_q;
    logic                  end_q;
    logic                  req_xfer;
    logic                  rsp_xfer;
    logic                  last_word;

    assign req_ready_o = state_q inside {T_CMD, T_ADR, T_CNT, T_WDATA, T_DRAIN};
    assign rsp_valid_o = (state_q == T_HDR) || (state_q == T_RDATA);
    assign req_xfer    = req_valid_i && req_ready_o;
    assign rsp_xfer    = rsp_valid_o && rsp_ready_i;
    assign last_word   = (left_q == 8'd1);

    // Header bytes by index, then read data least significant byte first
    always_comb begin
        rsp_o.last = 1'b0;
        case (idx_q)
            2'd0:    rsp_o.data = code_q;
            2'd1:    rsp_o.data = adr_q;
            default: rsp_o.data = cnt_q;
        endcase
        if (state_q == T_RDATA) begin
            rsp_o.data = word_q[{idx_q, 3'b000} +: `XFCP_DATA_W];
            rsp_o.last = (idx_q == 2'd3) && last_word;
        end else if (idx_q == 2'd2) begin
            rsp_o.last = (code_q != RSP_READ) || (cnt_q == 8'd0);
        end
    end

    // Full-word cycles only
    always_comb begin
        wb_o.adr = ptr_q;
        wb_o.dat = word_q;
        wb_o.we  = (state_q == T_WWB);
        wb_o.sel = '1;
        wb_o.stb = (state_q == T_WWB) || (state_q == T_RWB);
        wb_o.cyc = (state_q == T_WWB) || (state_q == T_RWB);
    end

    // Header fields and data word
    always_ff @(posedge clk) begin
        if (req_xfer) begin
            case (state_q)
                T_CMD: begin
                    case (req_i.data)
                        `XFCP_CMD_READ:  code_q <= req_i.last ? RSP_ERR : RSP_READ;
                        `XFCP_CMD_WRITE: code_q <= req_i.last ? RSP_ERR : RSP_WRITE;
                        default:         code_q <= RSP_ERR;
                    endcase
                end
                T_ADR: begin
                    adr_q <= req_i.data;
                    ptr_q <= req_i.data;
                    if (req_i.last) begin
                        code_q <= RSP_ERR;
                    end
                end
                T_CNT:   cnt_q <= req_i.data;
                T_WDATA: word_q[{idx_q, 3'b000} +: `XFCP_DATA_W] <= req_i.data;
                default: ;
            endcase
        end
        if (wb_i.ack && wb_o.stb) begin
            ptr_q <= ptr_q + 1'b1;
            if (state_q == T_RWB) begin
                word_q <= wb_i.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= T_CMD;
            idx_q   <= 2'd0;
            left_q  <= 8'd0;
            end_q   <= 1'b0;
        end else begin
            case (state_q)
                T_CMD, T_ADR: begin
                    if (req_xfer) begin
                        state_q <= req_i.last ? T_HDR : state_t'(state_q + 1'b1);
                    end
                end
                T_CNT: begin
                    if (req_xfer) begin
                        left_q <= req_i.data;
                        idx_q  <= 2'd0;
                        if (req_i.last) begin
                            state_q <= T_HDR;
                        end else if (code_q == RSP_WRITE && req_i.data != 8'd0) begin
                            state_q <= T_WDATA;
                        end else begin
                            state_q <= T_DRAIN;
                        end
                    end
                end
                T_WDATA: begin
                    if (req_xfer) begin
                        idx_q <= idx_q + 2'd1;
                        end_q <= req_i.last;
                        if (idx_q == 2'd3) begin
                            state_q <= T_WWB;
                        end else if (req_i.last) begin
                            // Partial word is discarded
                            idx_q   <= 2'd0;
                            state_q <= T_HDR;
                        end
                    end
                end
                T_WWB: begin
                    if (wb_i.ack) begin
                        left_q <= left_q - 8'd1;
                        if (end_q) begin
                            state_q <= T_HDR;
                        end else begin
                            state_q <= last_word ? T_DRAIN : T_WDATA;
                        end
                    end
                end
                T_DRAIN: begin
                    if (req_xfer && req_i.last) begin
                        state_q <= T_HDR;
                    end
                end
                T_HDR: begin
                    if (rsp_xfer) begin
                        idx_q <= idx_q + 2'd1;
                        if (rsp_o.last) begin
                            idx_q   <= 2'd0;
                            state_q <= T_CMD;
                        end else if (idx_q == 2'd2) begin
                            idx_q   <= 2'd0;
                            state_q <= T_RWB;
                        end
                    end
                end
                T_RWB: begin
                    if (wb_i.ack) begin
                        state_q <= T_RDATA;
                    end
                end
                default: begin
                    // Bus stays idle while the host stalls the response
                    if (rsp_xfer) begin
                        idx_q <= idx_q + 2'd1;
                        if (idx_q == 2'd3) begin
                            left_q  <= left_q - 8'd1;
                            state_q <= last_word ? T_CMD : T_RWB;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/xfcp_route_1x2.sv ====
// XFCP 1x2 router
// Takes the leading port byte off a request and steers the remainder to
// one target, then passes that target's response back up
`timescale 1ns/10ps
`include "xfcp_defs.svh"

module xfcp_route_1x2
    import xfcp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  xfcp_beat_t up_req_i,
    input  logic       up_req_valid_i,
    output logic       up_req_ready_o,
    output xfcp_beat_t up_rsp_o,
    output logic       up_rsp_valid_o,
    input  logic       up_rsp_ready_i,
    output logic       drop_o,
    output xfcp_beat_t dn_req_o         [`XFCP_PORTS],
    output logic       dn_req_valid_o   [`XFCP_PORTS],
    input  logic       dn_req_ready_i   [`XFCP_PORTS],
    input  xfcp_beat_t dn_rsp_i         [`XFCP_PORTS],
    input  logic       dn_rsp_valid_i   [`XFCP_PORTS],
    output logic       dn_rsp_ready_o   [`XFCP_PORTS]
);

    localparam int SEL_W = $clog2(`XFCP_PORTS);

    typedef enum logic [1:0] {R_PORT, R_FWD, R_DROP, R_RSP} state_t;

    state_t           state_q;
    logic [SEL_W-1:0] sel_q;
    logic             port_ok;
    logic             up_xfer;
    logic             rsp_xfer;

    assign port_ok = up_req_i.data < `XFCP_PORTS;

    // Port byte and discarded beats are always taken
    assign up_req_ready_o = (state_q == R_PORT) || (state_q == R_DROP) ||
                            ((state_q == R_FWD) && dn_req_ready_i[sel_q]);
    assign up_xfer = up_req_valid_i && up_req_ready_o;

    assign up_rsp_o       = dn_rsp_i[sel_q];
    assign up_rsp_valid_o = (state_q == R_RSP) && dn_rsp_valid_i[sel_q];
    assign rsp_xfer       = up_rsp_valid_o && up_rsp_ready_i;

    // A lone port byte counts as a dropped request as well
    assign drop_o = up_xfer && up_req_i.last &&
                    ((state_q == R_PORT) || (state_q == R_DROP));

    always_comb begin
        for (int i = 0; i < `XFCP_PORTS; i++) begin
            dn_req_o[i]       = up_req_i;
            dn_req_valid_o[i] = (state_q == R_FWD) && (sel_q == SEL_W'(i)) && up_req_valid_i;
            dn_rsp_ready_o[i] = (state_q == R_RSP) && (sel_q == SEL_W'(i)) && up_rsp_ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= R_PORT;
            sel_q   <= '0;
        end else begin
            case (state_q)
                R_PORT: begin
                    if (up_xfer) begin
                        sel_q <= up_req_i.data[SEL_W-1:0];
                        if (!up_req_i.last) begin
                            state_q <= port_ok ? R_FWD : R_DROP;
                        end
                    end
                end
                R_FWD: begin
                    if (up_xfer && up_req_i.last) begin
                        state_q <= R_RSP;
                    end
                end
                R_DROP: begin
                    if (up_xfer && up_req_i.last) begin
                        state_q <= R_PORT;
                    end
                end
                default: begin
                    if (rsp_xfer && up_rsp_o.last) begin
                        state_q <= R_PORT;
                        sel_q   <= '0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/xfcp_arb_2x1.sv ====
// XFCP 2x1 arbiter
// Merges two host request streams onto one downstream port. The winning
// host keeps the lock until its response has finished.
`timescale 1ns/10ps

module xfcp_arb_2x1
    import xfcp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  xfcp_beat_t up_req_i         [2],
    input  logic       up_req_valid_i   [2],
    output logic       up_req_ready_o   [2],
    output xfcp_beat_t up_rsp_o         [2],
    output logic       up_rsp_valid_o   [2],
    input  logic       up_rsp_ready_i   [2],
    output xfcp_beat_t down_req_o,
    output logic       down_req_valid_o,
    input  logic       down_req_ready_i,
    input  xfcp_beat_t down_rsp_i,
    input  logic       down_rsp_valid_i,
    output logic       down_rsp_ready_o,
    input  logic       drop_i
);

    typedef enum logic [1:0] {S_INIT, S_IDLE, S_REQ, S_RSP} state_t;

    state_t state_q;
    logic   owner_q;
    logic   grant;
    logic   req_open;
    logic   req_xfer;
    logic   rsp_xfer;

    // Owner also serves as the round-robin pointer
    always_comb begin
        grant = owner_q;
        if (state_q == S_IDLE) begin
            grant = (up_req_valid_i[0] && up_req_valid_i[1]) ? ~owner_q : up_req_valid_i[1];
        end
    end

    // Request beats flow straight through while idle or locked on a request
    assign req_open         = (state_q == S_IDLE) || (state_q == S_REQ);
    assign down_req_o       = up_req_i[grant];
    assign down_req_valid_o = req_open && up_req_valid_i[grant];
    assign req_xfer         = down_req_valid_o && down_req_ready_i;

    assign down_rsp_ready_o = (state_q == S_RSP) && up_rsp_ready_i[owner_q];
    assign rsp_xfer         = down_rsp_valid_i && down_rsp_ready_o;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            up_req_ready_o[i] = req_open && (grant == 1'(i)) && down_req_ready_i;
            up_rsp_o[i]       = down_rsp_i;
            up_rsp_valid_o[i] = (state_q == S_RSP) && (owner_q == 1'(i)) && down_rsp_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_INIT;
            owner_q <= 1'b1;
        end else begin
            case (state_q)
                S_INIT: state_q <= S_IDLE;
                S_IDLE, S_REQ: begin
                    if (req_xfer) begin
                        owner_q <= grant;
                        if (!down_req_o.last) begin
                            state_q <= S_REQ;
                        end else begin
                            // Dropped requests never get a response
                            state_q <= drop_i ? S_IDLE : S_RSP;
                        end
                    end
                end
                S_RSP: begin
                    if (rsp_xfer && down_rsp_i.last) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== design/xfcp_pkg.sv ====
// XFCP fabric types
// Stream beat plus the Wishbone request and response bundles
`include "xfcp_defs.svh"

package xfcp_pkg;

    // One byte of a command or response packet
    typedef struct packed {
        logic [`XFCP_DATA_W-1:0] data;
        logic                    last;
    } xfcp_beat_t;

    // Master to slave side of a Wishbone cycle
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
        logic                  we;
        logic [`WB_SEL_W-1:0]  sel;
        logic                  stb;
        logic                  cyc;
    } wb_req_t;

    // Slave to master side
    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat;
        logic                  ack;
    } wb_rsp_t;

endpackage

// ==== design/xfcp_defs.svh ====
// XFCP fabric constants
// Stream and Wishbone widths, command codes and router fan-out
`ifndef XFCP_DEFS_SVH
`define XFCP_DEFS_SVH

// Stream byte and Wishbone word geometry
`define XFCP_DATA_W 8
`define WB_DATA_W 32
`define WB_ADDR_W 8
`define WB_SEL_W 4

// Request codes
// Each response code is its request code plus one
`define XFCP_CMD_READ 8'h10
`define XFCP_CMD_WRITE 8'h12

// Router outputs
`define XFCP_PORTS 2

`endif
